/* tb.f */
hdl/bridge_pkg.sv
hdl/axi_read_engine.sv
hdl/axi_write_engine.sv
hdl/sram_resp_merge.sv
hdl/cpu_axi_bridge.sv
bench/axi_mem_model.sv
bench/tb_cpu_axi_bridge.sv

/* bench/tb_cpu_axi_bridge.sv */
`timescale 1ns/10ps

module tb_cpu_axi_bridge;
    import bridge_pkg::*;

    localparam int      TIMEOUT   = 50;
    localparam int      INST_RUNS = 100;
    localparam int      DATA_RUNS = 200;
    localparam axi_id_t INST_ID   = 4'd0;
    localparam axi_id_t DATA_ID   = 4'd1;

    logic      clk;
    logic      resetn;
    sram_req_t inst_req;
    sram_req_t data_req;
    logic      inst_addr_ok;
    logic      inst_data_ok;
    data_t     inst_rdata;
    logic      data_addr_ok;
    logic      data_data_ok;
    data_t     data_rdata;

    axi_id_t    arid;
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    axi_id_t    rid;
    data_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;
    axi_id_t    awid;
    addr_t      awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic       awvalid;
    logic       awready;
    axi_id_t    wid;
    data_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       wvalid;
    logic       wready;
    axi_id_t    bid;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    logic       stalled;

    // reference memory with the slave's word indexing
    data_t ref_mem [256];

    int          errors;
    int          checks;
    int          inst_issued;
    int          data_issued;
    int          inst_aok_cnt;
    int          inst_dok_cnt;
    int          data_aok_cnt;
    int          data_dok_cnt;
    int unsigned seed_val;

    cpu_axi_bridge DUT (.*);

    axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t fill_word(input int i);
        logic [7:0] b;
        b = i[7:0];
        return {b, b ^ 8'hc3, ~b, b * 8'd7};
    endfunction

    function automatic strb_t byte_mask(input size_t size, input logic [1:0] off);
        if (size == 2'd2) begin
            return 4'hf;
        end
        return (size == 2'd1) ? (4'b0011 << off) : (4'b0001 << off);
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
        data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, inst requests %0d, data requests %0d",
                 checks, errors, inst_issued, data_issued);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        $display("timeout at %0t ns, no %s within %0d cycles", $time, what, TIMEOUT);
        finish_run();
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cpu side requests
    ////////////////////////////////////////////////////////////////////////////

    task automatic inst_read(input int word);
        data_t exp;
        int    n;
        inst_req      = '0;
        inst_req.req  = 1'b1;
        inst_req.size = 2'd2;
        inst_req.addr = {22'd0, word[7:0], 2'b00};
        inst_issued++;
        n = 0;
        step_cycle();
        while (!inst_addr_ok) begin
            n++;
            if (n > TIMEOUT) begin
                fail_timeout("inst addr_ok");
            end
            step_cycle();
        end
        exp      = ref_mem[word];
        inst_req = '0;
        n = 0;
        step_cycle();
        while (!inst_data_ok) begin
            n++;
            if (n > TIMEOUT) begin
                fail_timeout("inst data_ok");
            end
            step_cycle();
        end
        expect_eq(inst_rdata, exp, "inst rdata");
    endtask

    // returns at addr_ok and leaves data_ok to the caller
    task automatic data_issue(input bit wr, input int word, input size_t size,
                              input logic [1:0] off, input data_t wd, output data_t rd_exp);
        int n;
        data_req       = '0;
        data_req.req   = 1'b1;
        data_req.wr    = wr;
        data_req.size  = size;
        data_req.wstrb = wr ? byte_mask(size, off) : 4'h0;
        data_req.addr  = {22'd0, word[7:0], off};
        data_req.wdata = wd;
        data_issued++;
        n = 0;
        step_cycle();
        while (!data_addr_ok) begin
            n++;
            if (n > TIMEOUT) begin
                fail_timeout("data addr_ok");
            end
            step_cycle();
        end
        rd_exp = ref_mem[word];
        if (wr) begin
            ref_mem[word] = merge_bytes(ref_mem[word], wd, byte_mask(size, off));
        end
        data_req = '0;
    endtask

    task automatic wait_data_ok(input int target);
        int n;
        n = 0;
        while (data_dok_cnt < target) begin
            n++;
            if (n > TIMEOUT) begin
                fail_timeout("data data_ok");
            end
            step_cycle();
        end
        expect_eq(data_dok_cnt, target, "data_ok count");
    endtask

    // one request or a read and a write in flight together
    task automatic random_data_group();
        bit         first_wr;
        bit         wr;
        bit         has_read;
        int         count;
        int         word;
        size_t      size;
        logic [1:0] off;
        data_t      exp;
        data_t      rd_exp;
        first_wr = $urandom_range(0, 1);
        count    = $urandom_range(1, 2);
        word     = $urandom_range(0, 127);
        has_read = 1'b0;
        for (int k = 0; k < count; k++) begin
            wr = (k == 0) ? first_wr : !first_wr;
            // half of the pairs hit the same word
            if (k == 1 && $urandom_range(0, 1)) begin
                word = $urandom_range(0, 127);
            end
            size = $urandom_range(0, 2);
            off  = (size == 2'd2) ? 2'd0 : 2'($urandom_range(0, 3));
            if (size == 2'd1) begin
                off[0] = 1'b0;
            end
            data_issue(wr, word, size, off, $urandom, exp);
            if (!wr) begin
                rd_exp   = exp;
                has_read = 1'b1;
            end
        end
        wait_data_ok(data_issued);
        if (has_read) begin
            expect_eq(data_rdata, rd_exp, "data rdata");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // pulse counters and axi field checks
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (resetn) begin
            if (inst_addr_ok) inst_aok_cnt++;
            if (inst_data_ok) inst_dok_cnt++;
            if (data_addr_ok) data_aok_cnt++;
            if (data_data_ok) data_dok_cnt++;
            if (arvalid) begin
                expect_eq(arlen, 8'h00, "arlen");
                expect_eq(arburst, 2'b01, "arburst");
                if (arid == DATA_ID) begin
                    expect_eq(arsize, {1'b0, data_req.size}, "data arsize");
                    expect_eq(araddr, data_req.addr, "data araddr");
                end else begin
                    expect_eq(arid, INST_ID, "arid");
                    expect_eq(arsize, {1'b0, inst_req.size}, "inst arsize");
                    expect_eq(araddr, inst_req.addr, "inst araddr");
                end
            end
            if (awvalid) begin
                expect_eq(awlen, 8'h00, "awlen");
                expect_eq(awburst, 2'b01, "awburst");
                expect_eq(awid, DATA_ID, "awid");
                expect_eq(awsize, {1'b0, data_req.size}, "awsize");
                expect_eq(awaddr, data_req.addr, "awaddr");
            end
            if (wvalid) begin
                expect_eq(wlast, 1'b1, "wlast");
                expect_eq(wid, DATA_ID, "wid");
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        data_t old_word;
        data_t rd_exp;
        int    data_base;
        seed_val = $urandom(32'hfee3);
        errors   = 0;
        checks   = 0;
        resetn   = 1'b0;
        inst_req = '0;
        data_req = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]       = fill_word(i);
            u_mem.words[i]   = fill_word(i);
        end
        step_cycle();
        step_cycle();
        resetn = 1'b1;

        // quiet after reset
        repeat (3) begin
            step_cycle();
            expect_eq({arvalid, awvalid, wvalid, rready, bready}, 5'd0, "axi idle");
            expect_eq({inst_addr_ok, inst_data_ok, data_addr_ok, data_data_ok}, 4'd0,
                      "cpu pulses idle");
        end

        inst_read(130);
        inst_read(255);
        expect_eq(data_aok_cnt + data_dok_cnt, 0, "data pulses from inst reads");

        // partial write then read of the same word
        old_word = ref_mem[5];
        data_issue(1'b1, 5, 2'd1, 2'd2, 32'hcafe_f00d, rd_exp);
        data_issue(1'b0, 5, 2'd2, 2'd0, 32'h0, rd_exp);
        wait_data_ok(data_issued);
        expect_eq(data_rdata, {16'hcafe, old_word[15:0]}, "read after partial write");

        // both ports in the same cycle
        fork
            inst_read(200);
            begin
                data_issue(1'b0, 9, 2'd2, 2'd0, 32'h0, rd_exp);
                wait_data_ok(data_issued);
                expect_eq(data_rdata, rd_exp, "data read beside inst read");
            end
        join
        // last inst data_ok is counted on the falling edge
        step_cycle();
        expect_eq(inst_aok_cnt, inst_issued, "inst addr_ok count");
        expect_eq(inst_dok_cnt, inst_issued, "inst data_ok count");
        expect_eq(data_aok_cnt, data_issued, "data addr_ok count");

        data_base = data_issued;
        fork
            begin
                repeat (INST_RUNS) begin
                    inst_read($urandom_range(128, 255));
                    repeat ($urandom_range(0, 2)) step_cycle();
                end
            end
            begin
                while (data_issued < data_base + DATA_RUNS) begin
                    random_data_group();
                    repeat ($urandom_range(0, 2)) step_cycle();
                end
            end
        join

        // late or extra pulses would show up here
        repeat (10) step_cycle();
        expect_eq(inst_aok_cnt, inst_issued, "final inst addr_ok count");
        expect_eq(inst_dok_cnt, inst_issued, "final inst data_ok count");
        expect_eq(data_aok_cnt, data_issued, "final data addr_ok count");
        expect_eq(data_dok_cnt, data_issued, "final data data_ok count");
        if (stalled) begin
            errors++;
            $display("the AXI memory gave up waiting for a handshake on R, W or B");
        end
        finish_run();
    end

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
    input  logic                clk,
    input  logic                resetn,
    // read side
    input  bridge_pkg::axi_id_t arid,
    input  bridge_pkg::addr_t   araddr,
    input  logic                arvalid,
    output logic                arready,
    output bridge_pkg::axi_id_t rid,
    output bridge_pkg::data_t   rdata,
    output logic [1:0]          rresp,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,
    // write side
    input  bridge_pkg::axi_id_t awid,
    input  bridge_pkg::addr_t   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  bridge_pkg::data_t   wdata,
    input  bridge_pkg::strb_t   wstrb,
    input  logic                wvalid,
    output logic                wready,
    output bridge_pkg::axi_id_t bid,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    // a handshake never completed
    output logic                stalled
);
    import bridge_pkg::*;

    localparam int HS_LIMIT = 50;

    // 256 words, indexed by address bits 9 to 2
    data_t words [256];

    task automatic random_delay();
        int d;
        d = $urandom_range(0, 3);
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // ar and r
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        axi_id_t id;
        data_t   word;
        int      n;
        logic    taken;
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rresp   = 2'b00;
        rlast   = 1'b1;
        stalled = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (resetn && arvalid) begin
                random_delay();
                // payload is held while arvalid waits
                id      = arid;
                word    = words[araddr[9:2]];
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                random_delay();
                rid    = id;
                rdata  = word;
                rvalid = 1'b1;
                n      = 0;
                taken  = 1'b0;
                while (!taken) begin
                    @(negedge clk);
                    taken = rready;
                    @(posedge clk);
                    #1;
                    n++;
                    if (!taken && n > HS_LIMIT) begin
                        stalled = 1'b1;
                        taken   = 1'b1;
                    end
                end
                rvalid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // aw, w and b
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        axi_id_t    id;
        logic [7:0] idx;
        data_t      wd;
        strb_t      ws;
        int         n;
        logic       taken;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bid     = '0;
        bresp   = 2'b00;
        forever begin
            @(posedge clk);
            #1;
            if (resetn && awvalid) begin
                random_delay();
                id      = awid;
                idx     = awaddr[9:2];
                awready = 1'b1;
                @(posedge clk);
                #1;
                awready = 1'b0;
                n = 0;
                while (!wvalid && n <= HS_LIMIT) begin
                    @(posedge clk);
                    #1;
                    n++;
                end
                if (!wvalid) begin
                    stalled = 1'b1;
                end else begin
                    random_delay();
                    wd     = wdata;
                    ws     = wstrb;
                    wready = 1'b1;
                    @(posedge clk);
                    #1;
                    wready = 1'b0;
                    // byte merge under the strobes
                    for (int b = 0; b < 4; b++) begin
                        if (ws[b]) begin
                            words[idx][8*b +: 8] = wd[8*b +: 8];
                        end
                    end
                    random_delay();
                    bid    = id;
                    bvalid = 1'b1;
                    n      = 0;
                    taken  = 1'b0;
                    while (!taken) begin
                        @(negedge clk);
                        taken = bready;
                        @(posedge clk);
                        #1;
                        n++;
                        if (!taken && n > HS_LIMIT) begin
                            stalled = 1'b1;
                            taken   = 1'b1;
                        end
                    end
                    bvalid = 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/cpu_axi_bridge.sv */
`timescale 1ns/10ps

module cpu_axi_bridge #(
    parameter bridge_pkg::axi_id_t INST_ID = 4'd0,
    parameter bridge_pkg::axi_id_t DATA_ID = 4'd1
) (
    input  logic                  clk,
    input  logic                  resetn,

    // cpu side
    input  bridge_pkg::sram_req_t inst_req,
    input  bridge_pkg::sram_req_t data_req,
    output logic                  inst_addr_ok,
    output logic                  inst_data_ok,
    output bridge_pkg::data_t     inst_rdata,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output bridge_pkg::data_t     data_rdata,

    // ar
    output bridge_pkg::axi_id_t   arid,
    output bridge_pkg::addr_t     araddr,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    output logic [1:0]            arburst,
    output logic                  arvalid,
    input  logic                  arready,
    // r, response and last not used for single beats
    input  bridge_pkg::axi_id_t   rid,
    input  bridge_pkg::data_t     rdata,
    input  logic [1:0]            rresp,
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready,
    // aw
    output bridge_pkg::axi_id_t   awid,
    output bridge_pkg::addr_t     awaddr,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,
    output logic                  awvalid,
    input  logic                  awready,
    // w
    output bridge_pkg::axi_id_t   wid,
    output bridge_pkg::data_t     wdata,
    output bridge_pkg::strb_t     wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    // b, only one write outstanding so bid is not checked
    input  bridge_pkg::axi_id_t   bid,
    input  logic [1:0]            bresp,
    input  logic                  bvalid,
    output logic                  bready
);
    import bridge_pkg::*;

    rd_event_t  rd_evt;
    wr_event_t  wr_evt;
    wr_hazard_t hazard;

    axi_read_engine #(
        .INST_ID (INST_ID),
        .DATA_ID (DATA_ID)
    ) u_rd (
        .clk      (clk),
        .resetn   (resetn),
        .inst_req (inst_req),
        .data_req (data_req),
        .hazard   (hazard),
        .arid     (arid),
        .araddr   (araddr),
        .arsize   (arsize),
        .arlen    (arlen),
        .arburst  (arburst),
        .arvalid  (arvalid),
        .arready  (arready),
        .rid      (rid),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready),
        .rd_evt   (rd_evt)
    );

    axi_write_engine #(
        .DATA_ID (DATA_ID)
    ) u_wr (
        .clk      (clk),
        .resetn   (resetn),
        .data_req (data_req),
        .awid     (awid),
        .awaddr   (awaddr),
        .awsize   (awsize),
        .awlen    (awlen),
        .awburst  (awburst),
        .awvalid  (awvalid),
        .awready  (awready),
        .wid      (wid),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .wr_evt   (wr_evt),
        .hazard   (hazard)
    );

    sram_resp_merge #(
        .INST_ID (INST_ID),
        .DATA_ID (DATA_ID)
    ) u_merge (
        .clk          (clk),
        .resetn       (resetn),
        .rd_evt       (rd_evt),
        .wr_evt       (wr_evt),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata)
    );

endmodule

/* hdl/sram_resp_merge.sv */
`timescale 1ns/10ps

module sram_resp_merge #(
    parameter bridge_pkg::axi_id_t INST_ID = 4'd0,
    parameter bridge_pkg::axi_id_t DATA_ID = 4'd1
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  bridge_pkg::rd_event_t rd_evt,
    input  bridge_pkg::wr_event_t wr_evt,
    output logic                  inst_addr_ok,
    output logic                  inst_data_ok,
    output bridge_pkg::data_t     inst_rdata,
    output logic                  data_addr_ok,
    output logic                  data_data_ok,
    output bridge_pkg::data_t     data_rdata
);
    import bridge_pkg::*;

    logic inst_acc;
    logic inst_ret;
    logic data_acc;
    logic data_ret;
    // write done that lost against a read return
    logic wr_done_pend;

    ////////////////////////////////////////////////////////////////////////////
    // route by id
    ////////////////////////////////////////////////////////////////////////////

    assign inst_acc = rd_evt.accept && (rd_evt.accept_id == INST_ID);
    assign inst_ret = rd_evt.ret && (rd_evt.ret_id == INST_ID);
    assign data_acc = rd_evt.accept && (rd_evt.accept_id == DATA_ID);
    assign data_ret = rd_evt.ret && (rd_evt.ret_id == DATA_ID);

    ////////////////////////////////////////////////////////////////////////////
    // pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_addr_ok <= 1'b0;
            inst_data_ok <= 1'b0;
            data_addr_ok <= 1'b0;
            data_data_ok <= 1'b0;
            wr_done_pend <= 1'b0;
        end else begin
            inst_addr_ok <= inst_acc;
            inst_data_ok <= inst_ret;
            // read and write accepts never overlap on the data port
            data_addr_ok <= data_acc || wr_evt.accept;
            data_data_ok <= data_ret || wr_evt.done || wr_done_pend;
            // collision, read goes now and write follows next cycle
            wr_done_pend <= data_ret && wr_evt.done;
        end
    end

    // read data, held between returns
    always_ff @(posedge clk) begin
        if (inst_ret) begin
            inst_rdata <= rd_evt.ret_data;
        end
        if (data_ret) begin
            data_rdata <= rd_evt.ret_data;
        end
    end

endmodule

/* hdl/axi_write_engine.sv */
`timescale 1ns/10ps

module axi_write_engine #(
    parameter bridge_pkg::axi_id_t DATA_ID = 4'd1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  bridge_pkg::sram_req_t  data_req,
    output bridge_pkg::axi_id_t    awid,
    output bridge_pkg::addr_t      awaddr,
    output logic [2:0]             awsize,
    output logic [7:0]             awlen,
    output logic [1:0]             awburst,
    output logic                   awvalid,
    input  logic                   awready,
    output bridge_pkg::axi_id_t    wid,
    output bridge_pkg::data_t      wdata,
    output bridge_pkg::strb_t      wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready,
    output bridge_pkg::wr_event_t  wr_evt,
    output bridge_pkg::wr_hazard_t hazard
);
    import bridge_pkg::*;

    wr_state_t state;
    wr_state_t state_next;
    logic      take_wr;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    assign take_wr = (state == WR_IDLE) && data_req.req && data_req.wr;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    ////////////////////////////////////////////////////////////////////////////
    // fsm, aw then w then b
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: begin
                if (take_wr) begin
                    state_next = WR_ADDR;
                end
            end
            WR_ADDR: begin
                if (aw_fire) begin
                    state_next = WR_DATA;
                end
            end
            WR_DATA: begin
                if (w_fire) begin
                    state_next = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_fire) begin
                    state_next = WR_IDLE;
                end
            end
            default: begin
                state_next = WR_IDLE;
            end
        endcase
    end

    // whole write captured up front, cpu may change wdata after addr_ok
    always_ff @(posedge clk) begin
        if (take_wr) begin
            awaddr <= data_req.addr;
            awsize <= {1'b0, data_req.size};
            wstrb  <= data_req.wstrb;
            wdata  <= data_req.wdata;
        end
    end

    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_DATA);
    assign bready  = (state == WR_RESP);

    assign awid    = DATA_ID;
    assign wid     = DATA_ID;
    assign awlen   = AXI_LEN_SINGLE;
    assign awburst = AXI_BURST_INCR;
    assign wlast   = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // events and hazard
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_evt.accept  = aw_fire;
        wr_evt.done    = b_fire;
        // busy from capture until the b handshake
        hazard.pending = (state != WR_IDLE);
        hazard.word    = awaddr[31:2];
    end

endmodule

/* hdl/axi_read_engine.sv */
`timescale 1ns/10ps

module axi_read_engine #(
    parameter bridge_pkg::axi_id_t INST_ID = 4'd0,
    parameter bridge_pkg::axi_id_t DATA_ID = 4'd1
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  bridge_pkg::sram_req_t  inst_req,
    input  bridge_pkg::sram_req_t  data_req,
    input  bridge_pkg::wr_hazard_t hazard,
    output bridge_pkg::axi_id_t    arid,
    output bridge_pkg::addr_t      araddr,
    output logic [2:0]             arsize,
    output logic [7:0]             arlen,
    output logic [1:0]             arburst,
    output logic                   arvalid,
    input  logic                   arready,
    input  bridge_pkg::axi_id_t    rid,
    input  bridge_pkg::data_t      rdata,
    input  logic                   rvalid,
    output logic                   rready,
    output bridge_pkg::rd_event_t  rd_evt
);
    import bridge_pkg::*;

    rd_state_t state;
    rd_state_t state_next;
    logic      data_blocked;
    logic      take_data;
    logic      take_inst;
    logic      ar_fire;
    logic      r_fire;

    ////////////////////////////////////////////////////////////////////////////
    // request selection
    ////////////////////////////////////////////////////////////////////////////

    // read after write to the same word waits for the b response
    assign data_blocked = hazard.pending && (hazard.word == data_req.addr[31:2]);

    // data side wins over fetch
    assign take_data = (state == RD_IDLE) && data_req.req && !data_req.wr && !data_blocked;
    assign take_inst = (state == RD_IDLE) && inst_req.req && !take_data;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    ////////////////////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE: begin
                if (take_data || take_inst) begin
                    state_next = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (ar_fire) begin
                    state_next = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (r_fire) begin
                    state_next = RD_IDLE;
                end
            end
            default: begin
                state_next = RD_IDLE;
            end
        endcase
    end

    // ar payload, stable while arvalid is up
    always_ff @(posedge clk) begin
        if (take_data) begin
            arid   <= DATA_ID;
            araddr <= data_req.addr;
            arsize <= {1'b0, data_req.size};
        end else if (take_inst) begin
            arid   <= INST_ID;
            araddr <= inst_req.addr;
            arsize <= {1'b0, inst_req.size};
        end
    end

    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_WAIT);
    assign arlen   = AXI_LEN_SINGLE;
    assign arburst = AXI_BURST_INCR;

    ////////////////////////////////////////////////////////////////////////////
    // events for the merger
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_evt.accept    = ar_fire;
        rd_evt.accept_id = arid;
        rd_evt.ret       = r_fire;
        rd_evt.ret_id    = rid;
        rd_evt.ret_data  = rdata;
    end

endmodule

/* hdl/bridge_pkg.sv */
package bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  axi_id_t;
    // log2 of the byte count
    typedef logic [1:0]  size_t;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // one cpu request, held until addr_ok
    typedef struct packed {
        logic  req;
        logic  wr;
        size_t size;
        strb_t wstrb;
        addr_t addr;
        data_t wdata;
    } sram_req_t;

    // read engine handshakes for the merger
    typedef struct packed {
        logic    accept;
        axi_id_t accept_id;
        logic    ret;
        axi_id_t ret_id;
        data_t   ret_data;
    } rd_event_t;

    typedef struct packed {
        logic accept;
        logic done;
    } wr_event_t;

    // word of the outstanding write
    typedef struct packed {
        logic        pending;
        logic [29:0] word;
    } wr_hazard_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_WAIT} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

    // fixed axi fields, single beat incrementing
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [7:0] AXI_LEN_SINGLE = 8'h00;

endpackage
